/* common/cnn_ctrl_pkg.sv */
`default_nettype none

package cnn_ctrl_pkg;

    // layer sequencer
    typedef enum logic [2:0] {
        LS_IDLE, LS_CONV, LS_DRAIN, LS_POOL, LS_NEXT, LS_FINISH
    } layer_state_e;

    // window fetch
    typedef enum logic [1:0] {FS_IDLE, FS_READ, FS_EMIT} fetch_state_e;

    // coefficient port opcode
    typedef enum logic {WRITE_KERNEL, WRITE_BIAS} coef_op_e;

endpackage

`default_nettype wire

/* common/cnn_defines.svh */
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// input image size
`define CNN_H 6
`define CNN_W 6

// output channels of the layer
`define CNN_OC 3

// image memory address width
`define CNN_ADDR_W 6

// arithmetic right shift applied to each sum
`define CNN_SHIFT 2

// credits granted by the downstream at reset
`define CNN_CREDITS 4

// output fifo entries
`define CNN_FIFO_DEPTH 4

`endif

/* common/cnn_types_pkg.sv */
`default_nettype none

package cnn_types_pkg;
    import cnn_ctrl_pkg::*;

    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [19:0] acc_t;

    // nine taps indexed by 3*row + col
    typedef weight_t [8:0] kernel_t;

    typedef struct packed {
        pixel_t [8:0] pix;
        logic [2:0]   row;
        logic [2:0]   col;
        logic         last;
    } window_t;

    typedef struct packed {
        logic [1:0] channel;
        logic [2:0] row;
        logic [2:0] col;
        pixel_t     value;
        logic       last;
    } result_beat_t;

    typedef struct packed {
        logic       valid;
        coef_op_e   op;
        logic [1:0] channel;
        logic [3:0] tap;
        weight_t    value;
    } coef_wr_t;

endpackage

`default_nettype wire

/* conv/conv_mac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module conv_mac
    import cnn_types_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire window_t     win,
    input  wire              win_valid,
    input  wire kernel_t     kernel,
    input  wire weight_t     bias,
    input  wire [1:0]        channel,
    output result_beat_t     beat,
    output logic             beat_valid
);

    typedef logic signed [15:0] prod_t;

    prod_t      prod [9];
    logic       valid1;
    logic [1:0] chan1;
    logic [2:0] row1;
    logic [2:0] col1;
    logic       last1;
    acc_t       sum;
    acc_t       scaled;
    acc_t       biased;

    function automatic pixel_t saturate(input acc_t v);
        if (v > acc_t'(127)) begin
            return 8'sd127;
        end else if (v < acc_t'(-128)) begin
            return -8'sd128;
        end
        return pixel_t'(v);
    endfunction

    // stage one forms the nine products
    always_ff @(posedge clk) begin
        for (int i = 0; i < 9; i++) begin
            prod[i] <= win.pix[i] * kernel[i];
        end
        chan1 <= channel;
        row1  <= win.row;
        col1  <= win.col;
        last1 <= win.last;
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < 9; i++) begin
            sum = sum + acc_t'(prod[i]);
        end
        scaled = sum >>> `CNN_SHIFT;
        biased = scaled + acc_t'(bias);
    end

    // stage two sums, scales, adds the bias and clamps
    always_ff @(posedge clk) begin
        beat.channel <= chan1;
        beat.row     <= row1;
        beat.col     <= col1;
        beat.value   <= saturate(biased);
        beat.last    <= last1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid1     <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            valid1     <= win_valid;
            beat_valid <= valid1;
        end
    end

endmodule

`default_nettype wire

/* conv/conv_window.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module conv_window
    import cnn_ctrl_pkg::*;
    import cnn_types_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    run,
    input  wire                    stall,
    output logic [`CNN_ADDR_W-1:0] addr1,
    output logic [`CNN_ADDR_W-1:0] addr2,
    input  wire pixel_t            data1,
    input  wire pixel_t            data2,
    output window_t                win,
    output logic                   win_valid,
    output logic                   scan_done
);

    localparam int AW    = `CNN_ADDR_W;
    localparam int OUT_H = `CNN_H - 2;
    localparam int OUT_W = `CNN_W - 2;

    fetch_state_e state;
    logic         active;
    logic [2:0]   row;
    logic [2:0]   col;
    // 0..4 issue reads, 1..5 collect data
    logic [2:0]   step;
    logic [3:0]   tap1;
    logic [3:0]   tap2;
    logic         last_pos;

    function automatic logic [AW-1:0] tap_addr(input logic [2:0] r, input logic [2:0] c,
                                               input logic [3:0] tap);
        logic [AW-1:0] dr;
        logic [AW-1:0] dc;
        dr = AW'(tap / 4'd3);
        dc = AW'(tap % 4'd3);
        return (AW'(r) + dr) * AW'(`CNN_W) + AW'(c) + dc;
    endfunction

    assign tap1     = {step, 1'b0};
    assign tap2     = (step == 3'd4) ? 4'd8 : {step, 1'b1};
    assign last_pos = (row == 3'(OUT_H - 1)) && (col == 3'(OUT_W - 1));

    always_comb begin
        addr1 = '0;
        addr2 = '0;
        if (state == FS_READ && step < 3'd5) begin
            addr1 = tap_addr(row, col, tap1);
            addr2 = tap_addr(row, col, tap2);
        end
    end

    // data of the pair issued one cycle earlier
    always_ff @(posedge clk) begin
        if (state == FS_READ && step != 3'd0) begin
            win.pix[tap1 - 4'd2] <= data1;
            if (step != 3'd5) begin
                win.pix[tap1 - 4'd1] <= data2;
            end
        end
        if (state == FS_READ && step == 3'd5) begin
            win.row  <= row;
            win.col  <= col;
            win.last <= last_pos;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= FS_IDLE;
            active    <= 1'b0;
            row       <= '0;
            col       <= '0;
            step      <= '0;
            win_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            win_valid <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                FS_IDLE: begin
                    if (run) begin
                        active <= 1'b1;
                        row    <= '0;
                        col    <= '0;
                    end
                    if ((run || active) && !stall) begin
                        step  <= '0;
                        state <= FS_READ;
                    end
                end
                FS_READ: begin
                    step <= step + 3'd1;
                    if (step == 3'd5) begin
                        win_valid <= 1'b1;
                        state     <= FS_EMIT;
                    end
                end
                FS_EMIT: begin
                    if (last_pos) begin
                        active    <= 1'b0;
                        scan_done <= 1'b1;
                        state     <= FS_IDLE;
                    end else begin
                        if (col == 3'(OUT_W - 1)) begin
                            col <= '0;
                            row <= row + 3'd1;
                        end else begin
                            col <= col + 3'd1;
                        end
                        // park in idle until the fifo has room again
                        if (stall) begin
                            state <= FS_IDLE;
                        end else begin
                            step  <= '0;
                            state <= FS_READ;
                        end
                    end
                end
                default: begin
                    state <= FS_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* layer1.f */
+incdir+common
common/cnn_ctrl_pkg.sv
common/cnn_types_pkg.sv
source/layer_control.sv
source/weight_bank.sv
conv/conv_window.sv
conv/conv_mac.sv
source/result_out.sv
source/layer1.sv
test/tb_layer1.sv

/* source/layer1.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module layer1
    import cnn_types_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire coef_wr_t          coef,
    output logic [`CNN_ADDR_W-1:0] addr1,
    output logic [`CNN_ADDR_W-1:0] addr2,
    input  wire pixel_t            data1,
    input  wire pixel_t            data2,
    output result_beat_t           res,
    output logic                   res_valid,
    input  wire                    credit_ret,
    output logic                   pool,
    input  wire                    pool_done,
    output logic                   done
);

    logic         run;
    logic [1:0]   channel;
    logic         scan_done;
    logic         empty;
    logic         stall;
    kernel_t      kernel;
    weight_t      bias;
    window_t      win;
    logic         win_valid;
    result_beat_t beat;
    logic         beat_valid;

    layer_control layer_control_inst (
        .clk(clk), .rst_n(rst_n), .start(start), .scan_done(scan_done),
        .empty(empty), .pool_done(pool_done), .run(run), .channel(channel),
        .pool(pool), .done(done)
    );

    weight_bank weight_bank_inst (
        .clk(clk), .rst_n(rst_n), .coef(coef), .channel(channel),
        .kernel(kernel), .bias(bias)
    );

    conv_window conv_window_inst (
        .clk(clk), .rst_n(rst_n), .run(run), .stall(stall),
        .addr1(addr1), .addr2(addr2), .data1(data1), .data2(data2),
        .win(win), .win_valid(win_valid), .scan_done(scan_done)
    );

    conv_mac conv_mac_inst (
        .clk(clk), .rst_n(rst_n), .win(win), .win_valid(win_valid),
        .kernel(kernel), .bias(bias), .channel(channel),
        .beat(beat), .beat_valid(beat_valid)
    );

    result_out result_out_inst (
        .clk(clk), .rst_n(rst_n), .beat(beat), .beat_valid(beat_valid),
        .credit_ret(credit_ret), .res(res), .res_valid(res_valid),
        .stall(stall), .empty(empty)
    );

endmodule

`default_nettype wire

/* source/layer_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module layer_control
    import cnn_ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        start,
    input  wire        scan_done,
    input  wire        empty,
    input  wire        pool_done,
    output logic       run,
    output logic [1:0] channel,
    output logic       pool,
    output logic       done
);

    layer_state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= LS_IDLE;
            channel <= '0;
        end else begin
            case (state)
                LS_IDLE: begin
                    if (start) begin
                        channel <= '0;
                        state   <= LS_NEXT;
                    end
                end
                LS_NEXT: begin
                    state <= LS_CONV;
                end
                LS_CONV: begin
                    if (scan_done) begin
                        state <= LS_DRAIN;
                    end
                end
                // wait until the last beat has left the fifo
                LS_DRAIN: begin
                    if (empty) begin
                        state <= LS_POOL;
                    end
                end
                LS_POOL: begin
                    if (pool_done) begin
                        if (channel == 2'(`CNN_OC - 1)) begin
                            state <= LS_FINISH;
                        end else begin
                            channel <= channel + 2'd1;
                            state   <= LS_NEXT;
                        end
                    end
                end
                LS_FINISH: begin
                    state <= LS_IDLE;
                end
                default: begin
                    state <= LS_IDLE;
                end
            endcase
        end
    end

    assign run  = (state == LS_NEXT);
    assign pool = (state == LS_POOL);
    assign done = (state == LS_FINISH);

    // the window walk only finishes while a scan is running
    a_scan_in_conv: assert property (@(posedge clk) disable iff (!rst_n)
        scan_done |-> state == LS_CONV);

endmodule

`default_nettype wire

/* source/result_out.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module result_out
    import cnn_types_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire result_beat_t beat,
    input  wire               beat_valid,
    input  wire               credit_ret,
    output result_beat_t      res,
    output logic              res_valid,
    output logic              stall,
    output logic              empty
);

    localparam int DEPTH = `CNN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`CNN_CREDITS + 1);

    result_beat_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             have_data;
    logic             send;
    logic             pop;
    logic             push;

    assign have_data = (count != '0);
    assign send      = (have_data || beat_valid) && (credits != '0);
    assign pop       = send && have_data;
    // with an empty fifo the incoming beat goes straight out
    assign push      = beat_valid && !(send && !have_data);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= beat;
        end
        if (send) begin
            res <= have_data ? mem[rd_ptr] : beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CRD_W'(`CNN_CREDITS);
            res_valid <= 1'b0;
        end else begin
            res_valid <= send;
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count   <= count + CNT_W'(push) - CNT_W'(pop);
            credits <= credits - CRD_W'(send) + CRD_W'(credit_ret);
        end
    end

    // two slots stay free for the beats inside the mac
    assign stall = (count >= CNT_W'(DEPTH - 2));
    assign empty = (count == '0) && !beat_valid;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count < CNT_W'(DEPTH));

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRD_W'(`CNN_CREDITS));

endmodule

`default_nettype wire

/* source/weight_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module weight_bank
    import cnn_ctrl_pkg::*;
    import cnn_types_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire coef_wr_t coef,
    input  wire [1:0]     channel,
    output kernel_t       kernel,
    output weight_t       bias
);

    kernel_t kern_mem [`CNN_OC];
    weight_t bias_mem [`CNN_OC];

    always_ff @(posedge clk) begin
        if (coef.valid && coef.channel < 2'(`CNN_OC)) begin
            if (coef.op == WRITE_KERNEL) begin
                if (coef.tap < 4'd9) begin
                    kern_mem[coef.channel][coef.tap] <= coef.value;
                end
            end else begin
                bias_mem[coef.channel] <= coef.value;
            end
        end
    end

    // coefficients of the channel being processed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kernel <= '0;
            bias   <= '0;
        end else begin
            kernel <= kern_mem[channel];
            bias   <= bias_mem[channel];
        end
    end

    a_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
        coef.valid && coef.op == WRITE_KERNEL |-> coef.tap < 4'd9);

endmodule

`default_nettype wire

/* test/layer1_cases.txt */
// per case: 6 image rows, 3 kernels of taps 0..8, 3 biases,
// then 4 rows of 4 expected outputs per channel, all 8-bit two's complement hex
// case 0: ramp image, pixel = address - 20
ec ed ee ef f0 f1
f2 f3 f4 f5 f6 f7
f8 f9 fa fb fc fd
fe ff 00 01 02 03
04 05 06 07 08 09
0a 0b 0c 0d 0e 0f
01 01 01 01 01 01 01 01 01
00 00 00 00 04 00 00 00 00
fd 00 00 00 00 00 00 00 05
01 fd f6
e3 e6 e8 ea
f1 f3 f5 f8
fe 01 03 05
0c 0e 10 13
f0 f1 f2 f3
f6 f7 f8 f9
fc fd fe ff
02 03 04 05
fd fe fe ff
00 01 01 02
03 04 04 05
06 07 07 08
// case 1: left half 100, right half -100, large weights
64 64 64 9c 9c 9c
64 64 64 9c 9c 9c
64 64 64 9c 9c 9c
64 64 64 9c 9c 9c
64 64 64 9c 9c 9c
64 64 64 9c 9c 9c
0a 0a 0a 0a 0a 0a 0a 0a 0a
00 00 00 00 01 00 00 00 00
7f 00 80 00 00 00 00 00 00
00 05 f9
7f 7f 80 80
7f 7f 80 80
7f 7f 80 80
7f 7f 80 80
1e 1e ec ec
1e 1e ec ec
1e 1e ec ec
1e 1e ec ec
e0 7f 7f 12
e0 7f 7f 12
e0 7f 7f 12
e0 7f 7f 12

/* test/tb_layer1.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cnn_defines.svh"

module tb_layer1
    import cnn_ctrl_pkg::*;
    import cnn_types_pkg::*;
();

    localparam int N_CASES    = 2;
    localparam int IMG_SIZE   = `CNN_H * `CNN_W;
    localparam int OUT_W      = `CNN_W - 2;
    localparam int N_OUT      = (`CNN_H - 2) * OUT_W;
    localparam int KERN_OFS   = IMG_SIZE;
    localparam int BIAS_OFS   = KERN_OFS + `CNN_OC * 9;
    localparam int EXP_OFS    = BIAS_OFS + `CNN_OC;
    localparam int CASE_WORDS = EXP_OFS + `CNN_OC * N_OUT;
    localparam int MEM_SIZE   = 1 << `CNN_ADDR_W;
    localparam int WATCHDOG_CYCLES = N_CASES * `CNN_OC * N_OUT * 40;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    coef_wr_t               coef;
    logic [`CNN_ADDR_W-1:0] addr1;
    logic [`CNN_ADDR_W-1:0] addr2;
    pixel_t                 data1;
    pixel_t                 data2;
    result_beat_t           res;
    logic                   res_valid;
    logic                   credit_ret;
    logic                   pool;
    logic                   pool_done;
    logic                   done;

    logic [7:0]             cases_mem [N_CASES * CASE_WORDS];
    pixel_t                 img [MEM_SIZE];
    logic [`CNN_ADDR_W-1:0] rd_addr1 = '0;
    logic [`CNN_ADDR_W-1:0] rd_addr2 = '0;

    int cur_base;
    int chan_exp;
    int beat_idx;
    int case_beats;
    int done_count;
    int owed;
    int sat_hi;
    int sat_lo;
    int checks;
    int errors;
    logic pool_seen;

    layer1 u_layer1 (
        .clk(clk), .rst_n(rst_n), .start(start), .coef(coef),
        .addr1(addr1), .addr2(addr2), .data1(data1), .data2(data2),
        .res(res), .res_valid(res_valid), .credit_ret(credit_ret),
        .pool(pool), .pool_done(pool_done), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic string beat_text(input result_beat_t b);
        return $sformatf("ch %0d r %0d c %0d val %0d last %0b",
                         b.channel, b.row, b.col, b.value, b.last);
    endfunction

    task automatic check_beat(input result_beat_t got, input result_beat_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: beat %s, want %s", $time, beat_text(got), beat_text(exp));
        end
    endtask

    task automatic check_done(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic write_coef(input coef_op_e op, input int ch, input int tap,
                              input logic [7:0] value);
        @(posedge clk);
        #1;
        coef.valid   = 1'b1;
        coef.op      = op;
        coef.channel = 2'(ch);
        coef.tap     = 4'(tap);
        coef.value   = weight_t'(value);
    endtask

    // expected value from the file and position from the raster index
    task automatic take_beat();
        result_beat_t exp;
        case_beats++;
        if (pool) begin
            errors++;
            $display("beat sent at %0t ns while pool is still high", $time);
        end
        if (chan_exp >= `CNN_OC || beat_idx >= N_OUT) begin
            errors++;
            $display("extra beat at %0t ns beyond the expected outputs", $time);
        end else begin
            exp.channel = 2'(chan_exp);
            exp.row     = 3'(beat_idx / OUT_W);
            exp.col     = 3'(beat_idx % OUT_W);
            exp.value   = pixel_t'(cases_mem[cur_base + EXP_OFS + chan_exp * N_OUT + beat_idx]);
            exp.last    = (beat_idx == N_OUT - 1);
            check_beat(res, exp);
        end
        if (res.value == 8'sd127) begin
            sat_hi++;
        end
        if (res.value == -8'sd128) begin
            sat_lo++;
        end
        beat_idx++;
        owed++;
        if (owed > `CNN_CREDITS) begin
            errors++;
            $display("more than %0d beats outstanding without credit at %0t ns",
                     `CNN_CREDITS, $time);
        end
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        rd_addr1 = addr1;
        rd_addr2 = addr2;
        if (rst_n) begin
            if (pool_done) begin
                chan_exp++;
                beat_idx = 0;
            end
            if (res_valid) begin
                take_beat();
            end
            if (pool && !pool_seen) begin
                check_done("beats before pool", beat_idx, N_OUT);
            end
            pool_seen = pool;
            if (done) begin
                done_count++;
                check_done("channels before done", chan_exp, `CNN_OC);
            end
        end
    end

    // synchronous read one cycle after the address
    initial begin : image_memory
        data1 = '0;
        data2 = '0;
        forever begin
            @(posedge clk);
            #1;
            data1 = img[rd_addr1];
            data2 = img[rd_addr2];
        end
    end

    initial begin : credit_return
        int unsigned gap;
        credit_ret = 1'b0;
        forever begin
            @(posedge clk);
            if (owed > 0) begin
                gap = $urandom_range(6, 0);
                repeat (gap) @(posedge clk);
                #1;
                credit_ret = 1'b1;
                owed--;
                @(posedge clk);
                #1;
                credit_ret = 1'b0;
            end
        end
    end

    // external pooling stage
    initial begin : pool_model
        int unsigned gap;
        pool_done = 1'b0;
        forever begin
            @(negedge clk);
            if (pool) begin
                gap = $urandom_range(5, 1);
                repeat (gap) @(posedge clk);
                #1;
                pool_done = 1'b1;
                @(posedge clk);
                #1;
                pool_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic run_case(input int k);
        int errors_before;
        errors_before = errors;
        cur_base      = k * CASE_WORDS;
        for (int a = 0; a < MEM_SIZE; a++) begin
            if (a < IMG_SIZE) begin
                img[a] = pixel_t'(cases_mem[cur_base + a]);
            end else begin
                img[a] = pixel_t'(a * 7 + 3);
            end
        end
        for (int ch = 0; ch < `CNN_OC; ch++) begin
            for (int t = 0; t < 9; t++) begin
                write_coef(WRITE_KERNEL, ch, t, cases_mem[cur_base + KERN_OFS + ch * 9 + t]);
            end
            write_coef(WRITE_BIAS, ch, 0, cases_mem[cur_base + BIAS_OFS + ch]);
        end
        @(posedge clk);
        #1;
        coef.valid = 1'b0;
        chan_exp   = 0;
        beat_idx   = 0;
        case_beats = 0;
        done_count = 0;
        sat_hi     = 0;
        sat_lo     = 0;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        check_done("channels finished", chan_exp, `CNN_OC);
        check_done("done pulses", done_count, 1);
        check_done("beats in case", case_beats, `CNN_OC * N_OUT);
        // second case drives the clamp at both ends
        if (k == 1 && (sat_hi == 0 || sat_lo == 0)) begin
            errors++;
            $display("case %0d did not produce both clamped values", k);
        end
        $display("case %0d: %0d beats over %0d channels, %0d errors",
                 k, case_beats, chan_exp, errors - errors_before);
    endtask

    initial begin : main
        void'($urandom(60));
        checks    = 0;
        errors    = 0;
        owed      = 0;
        chan_exp  = 0;
        beat_idx  = 0;
        pool_seen = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        coef      = '0;
        $readmemh("test/layer1_cases.txt", cases_mem);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < N_CASES; k++) begin
            run_case(k);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
